// ==== hw/dphy_rx_pkg.sv ====
package dphy_rx_pkg;

    // ------------------------------------------------------------
    //  lane and word geometry
    // ------------------------------------------------------------
    localparam int LANES  = 2;                  // framing pairs exactly two bytes
    localparam int BYTE_W = 8;                  // one hs byte per lane per clock
    localparam int WORD_W = LANES * BYTE_W;     // lane 1 in high byte

    typedef logic [BYTE_W-1:0] byte_t;
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [1:0]        lp_t;            // {p, n} lp receiver levels

    // lp line levels, p in bit 1
    localparam lp_t LP_11 = 2'b11;              // stop
    localparam lp_t LP_01 = 2'b01;              // hs request
    localparam lp_t LP_00 = 2'b00;              // bridge, also seen during hs

    localparam byte_t SYNC_BYTE = 8'hb8;        // hs sync with aligner bypassed

    // ------------------------------------------------------------
    //  lane 0 lp sequence states
    // ------------------------------------------------------------
    localparam int lp_state_w = 2;

    typedef enum logic [lp_state_w-1:0] {
        LP_STOP    = 2'd0,                      // lp-11 seen
        LP_HS_RQST = 2'd1,                      // lp-01 after stop
        LP_BRIDGE  = 2'd2,                      // lp-00 after request
        LP_HS      = 2'd3                       // burst running, wait for lp-11
    } lp_state_e;

endpackage

// ==== hw/lp_state_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module lp_state_monitor (
    input  var logic                          mipi_dphy_rx_clk,
    input  var logic                          in_reset,
    input  var dphy_rx_pkg::lp_t              lp_d0,          // lane 0 lp levels
    input  var dphy_rx_pkg::lp_t              lp_d1,          // lane 1 lp levels
    output var logic [dphy_rx_pkg::LANES-1:0] odt_en,         // per lane termination
    output var logic                          aligner_reset   // one pulse per burst
);

    // ------------------------------------------------------------
    //  lane 0 lp sampling
    // ------------------------------------------------------------
    dphy_rx_pkg::lp_t lp0_s1;                       // first stage holds newest sample
    dphy_rx_pkg::lp_t lp0_s2;                       // second stage feeds the fsm

    always_ff @(posedge mipi_dphy_rx_clk or posedge in_reset) begin
        if (in_reset) begin
            lp0_s1 <= dphy_rx_pkg::LP_11;           // treat lines as idle
            lp0_s2 <= dphy_rx_pkg::LP_11;
        end else begin
            lp0_s1 <= lp_d0;
            lp0_s2 <= lp0_s1;
        end
    end

    // ------------------------------------------------------------
    //  entry sequence fsm
    // ------------------------------------------------------------
    dphy_rx_pkg::lp_state_e state_q;
    dphy_rx_pkg::lp_state_e state_d;
    logic                   hs_entry;               // rqst -> bridge on this edge
    logic                   term_phase;             // lanes may carry hs now

    always_comb begin
        state_d = state_q;                          // hold unless the line moves
        case (state_q)
            dphy_rx_pkg::LP_STOP: begin
                if (lp0_s2 == dphy_rx_pkg::LP_01)
                    state_d = dphy_rx_pkg::LP_HS_RQST;
            end
            dphy_rx_pkg::LP_HS_RQST: begin
                if (lp0_s2 == dphy_rx_pkg::LP_00)
                    state_d = dphy_rx_pkg::LP_BRIDGE;
                else if (lp0_s2 != dphy_rx_pkg::LP_01)
                    state_d = dphy_rx_pkg::LP_STOP; // 11 or 10 aborts request
            end
            dphy_rx_pkg::LP_BRIDGE: begin
                if (lp0_s2 == dphy_rx_pkg::LP_00)
                    state_d = dphy_rx_pkg::LP_HS;   // bridge held so burst begins
                else
                    state_d = dphy_rx_pkg::LP_STOP;
            end
            dphy_rx_pkg::LP_HS: begin
                if (lp0_s2 == dphy_rx_pkg::LP_11)
                    state_d = dphy_rx_pkg::LP_STOP; // end of transmission
            end
            default: state_d = dphy_rx_pkg::LP_STOP;
        endcase
    end

    assign hs_entry = (state_q == dphy_rx_pkg::LP_HS_RQST)
                   && (state_d == dphy_rx_pkg::LP_BRIDGE);

    always_ff @(posedge mipi_dphy_rx_clk or posedge in_reset) begin
        if (in_reset) begin
            state_q       <= dphy_rx_pkg::LP_STOP;
            aligner_reset <= 1'b0;
        end else begin
            state_q       <= state_d;
            aligner_reset <= hs_entry;              // lands with bridge state
        end
    end

    // termination follows the raw lp inputs masked by the fsm
    assign term_phase = (state_q == dphy_rx_pkg::LP_BRIDGE)
                     || (state_q == dphy_rx_pkg::LP_HS);
    assign odt_en[0]  = term_phase && (lp_d0 == dphy_rx_pkg::LP_00);
    assign odt_en[1]  = term_phase && (lp_d1 == dphy_rx_pkg::LP_00);

    // aligner reset is a single pulse
    aligner_reset_single: assert property (
        @(posedge mipi_dphy_rx_clk) disable iff (in_reset)
        aligner_reset |=> !aligner_reset
    );

endmodule

`default_nettype wire

// ==== hw/hs_settle_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module hs_settle_timer #(
    parameter int SETTLE_CYCLES = 10                // hs tail kept after lp-00 ends
) (
    input  var logic mipi_dphy_rx_clk,
    input  var logic in_reset,
    input  var logic term_active,                   // any lane terminated
    output var logic hs_window                      // capture allowed
);

    // ------------------------------------------------------------
    //  settle countdown
    // ------------------------------------------------------------
    localparam int CNT_W = $clog2(SETTLE_CYCLES + 1);

    logic [CNT_W-1:0] count;                        // cycles of window left

    always_ff @(posedge mipi_dphy_rx_clk or posedge in_reset) begin
        if (in_reset) begin
            count     <= '0;
            hs_window <= 1'b0;
        end else begin
            if (term_active)
                count <= CNT_W'(SETTLE_CYCLES);     // reload while terminated
            else if (count != '0)
                count <= count - CNT_W'(1);         // drain after lp-00 ends
            hs_window <= (count != '0);             // one cycle behind count
        end
    end

    // reload value is the ceiling, nothing counts past it
    count_in_range: assert property (
        @(posedge mipi_dphy_rx_clk) disable iff (in_reset)
        count <= CNT_W'(SETTLE_CYCLES)
    );

endmodule

`default_nettype wire

// ==== hw/hs_byte_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

module hs_byte_capture (
    input  var logic               mipi_dphy_rx_clk,
    input  var logic               in_reset,
    input  var dphy_rx_pkg::byte_t hs_d0,           // lane 0 deserialiser byte
    input  var dphy_rx_pkg::byte_t hs_d1,           // lane 1 deserialiser byte
    input  var logic               hs_vld,          // phy valid, lane 0
    input  var logic               hs_window,       // settle window open
    output var dphy_rx_pkg::word_t w_data,
    output var logic               w_valid,
    output var logic               w_first,         // first kept word of burst
    output var logic               w_last           // no pair follows this word
);

    // ------------------------------------------------------------
    //  stage 1, gated pair register
    // ------------------------------------------------------------
    logic               pair_vld;                   // gated pair held in d*_q
    dphy_rx_pkg::byte_t d0_q;
    dphy_rx_pkg::byte_t d1_q;
    logic               burst_q;                    // pair_vld one cycle back
    logic               first_pend;                 // sync dropped, first flag owed

    logic               burst_start;                // pair opens a burst
    logic               sync_pair;                  // b8 on both lanes
    logic               keep;                       // pair becomes a word

    assign burst_start = pair_vld && !burst_q;
    assign sync_pair   = (d0_q == dphy_rx_pkg::SYNC_BYTE)
                      && (d1_q == dphy_rx_pkg::SYNC_BYTE);
    assign keep        = pair_vld && !(burst_start && sync_pair);

    // ------------------------------------------------------------
    //  control and stage 2 flags
    // ------------------------------------------------------------
    always_ff @(posedge mipi_dphy_rx_clk or posedge in_reset) begin
        if (in_reset) begin
            pair_vld   <= 1'b0;
            burst_q    <= 1'b0;
            first_pend <= 1'b0;
            w_valid    <= 1'b0;
            w_first    <= 1'b0;
        end else begin
            pair_vld   <= hs_vld && hs_window;      // drop anything outside window
            burst_q    <= pair_vld;
            first_pend <= burst_start && sync_pair; // next pair carries first
            w_valid    <= keep;
            w_first    <= keep && (burst_start || first_pend);
        end
    end

    // payload only moves with a valid pair
    always_ff @(posedge mipi_dphy_rx_clk) begin
        if (hs_vld && hs_window) begin
            d0_q <= hs_d0;
            d1_q <= hs_d1;
        end
        if (keep)
            w_data <= {d1_q, d0_q};                 // lane 1 high byte
    end

    // stage 1 already shows whether the burst continues
    assign w_last = w_valid && !pair_vld;

    // frame flags never stand alone
    flags_need_valid: assert property (
        @(posedge mipi_dphy_rx_clk) disable iff (in_reset)
        (w_first || w_last) |-> w_valid
    );

endmodule

`default_nettype wire

// ==== hw/burst_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module burst_fifo #(
    parameter int FIFO_DEPTH = 16                   // power of two
) (
    input  var logic               mipi_dphy_rx_clk,
    input  var logic               in_reset,
    input  var dphy_rx_pkg::word_t w_data,
    input  var logic               w_first,
    input  var logic               w_last,
    input  var logic               w_valid,         // no ready, drop when full
    output var dphy_rx_pkg::word_t m_data,
    output var logic               m_first,
    output var logic               m_last,
    output var logic               m_valid,
    input  var logic               m_ready,
    output var logic               overflow         // sticky until reset
);

    // ------------------------------------------------------------
    //  storage
    // ------------------------------------------------------------
    localparam int AW = $clog2(FIFO_DEPTH);
    localparam int CW = AW + 1;                     // count reaches FIFO_DEPTH
    localparam int EW = dphy_rx_pkg::WORD_W + 2;    // {first, last, data}

    logic [EW-1:0] mem [FIFO_DEPTH];
    logic [EW-1:0] rd_entry;
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;                           // words held
    logic          full;
    logic          do_wr;
    logic          do_rd;

    assign full  = (count == CW'(FIFO_DEPTH));
    assign do_wr = w_valid && !full;
    assign do_rd = m_valid && m_ready;

    always_ff @(posedge mipi_dphy_rx_clk) begin
        if (do_wr)
            mem[wr_ptr] <= {w_first, w_last, w_data};
    end

    assign rd_entry = mem[rd_ptr];                  // head word, steady while stalled
    assign m_first  = rd_entry[EW-1];
    assign m_last   = rd_entry[EW-2];
    assign m_data   = rd_entry[dphy_rx_pkg::WORD_W-1:0];
    assign m_valid  = (count != '0);

    // ------------------------------------------------------------
    //  pointers, fill count, overflow
    // ------------------------------------------------------------
    always_ff @(posedge mipi_dphy_rx_clk or posedge in_reset) begin
        if (in_reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_wr)
                wr_ptr <= wr_ptr + AW'(1);          // wraps, depth is 2**AW
            if (do_rd)
                rd_ptr <= rd_ptr + AW'(1);
            case ({do_wr, do_rd})
                2'b10:   count <= count + CW'(1);
                2'b01:   count <= count - CW'(1);
                default: count <= count;            // both or neither
            endcase
            if (w_valid && full)
                overflow <= 1'b1;                   // word lost
        end
    end

    fill_in_range: assert property (
        @(posedge mipi_dphy_rx_clk) disable iff (in_reset)
        count <= CW'(FIFO_DEPTH)
    );

    // stalled head must not change under the consumer
    head_stable: assert property (
        @(posedge mipi_dphy_rx_clk) disable iff (in_reset)
        (m_valid && !m_ready) |=> $stable({m_first, m_last, m_data})
    );

endmodule

`default_nettype wire

// ==== hw/dphy_byte_rx_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dphy_byte_rx_top #(
    parameter int SETTLE_CYCLES = 10,               // hs window after termination
    parameter int FIFO_DEPTH    = 16                // output buffer words
) (
    input  var logic                          mipi_dphy_rx_clk,
    input  var logic                          in_reset,

    input  var dphy_rx_pkg::lp_t              lp_d0,
    input  var dphy_rx_pkg::lp_t              lp_d1,
    input  var dphy_rx_pkg::byte_t            hs_d0,
    input  var dphy_rx_pkg::byte_t            hs_d1,
    input  var logic                          hs_vld,

    output var logic [dphy_rx_pkg::LANES-1:0] odt_en,
    output var logic                          aligner_reset,

    output var dphy_rx_pkg::word_t            m_data,
    output var logic                          m_valid,
    output var logic                          m_first,
    output var logic                          m_last,
    input  var logic                          m_ready,
    output var logic                          overflow
);

    // ------------------------------------------------------------
    //  internal links
    // ------------------------------------------------------------
    logic               hs_window;                  // timer -> capture
    dphy_rx_pkg::word_t w_data;                     // capture -> fifo
    logic               w_valid;
    logic               w_first;
    logic               w_last;

    lp_state_monitor u_lp_state_monitor (
        .mipi_dphy_rx_clk (mipi_dphy_rx_clk),
        .in_reset         (in_reset        ),
        .lp_d0            (lp_d0           ),
        .lp_d1            (lp_d1           ),
        .odt_en           (odt_en          ),
        .aligner_reset    (aligner_reset   )
    );

    hs_settle_timer #(
        .SETTLE_CYCLES    (SETTLE_CYCLES   )
    ) u_hs_settle_timer (
        .mipi_dphy_rx_clk (mipi_dphy_rx_clk),
        .in_reset         (in_reset        ),
        .term_active      (|odt_en         ),  // either lane terminated
        .hs_window        (hs_window       )
    );

    hs_byte_capture u_hs_byte_capture (
        .mipi_dphy_rx_clk (mipi_dphy_rx_clk),
        .in_reset         (in_reset        ),
        .hs_d0            (hs_d0           ),
        .hs_d1            (hs_d1           ),
        .hs_vld           (hs_vld          ),
        .hs_window        (hs_window       ),
        .w_data           (w_data          ),
        .w_valid          (w_valid         ),
        .w_first          (w_first         ),
        .w_last           (w_last          )
    );

    burst_fifo #(
        .FIFO_DEPTH       (FIFO_DEPTH      )
    ) u_burst_fifo (
        .mipi_dphy_rx_clk (mipi_dphy_rx_clk),
        .in_reset         (in_reset        ),
        .w_data           (w_data          ),
        .w_first          (w_first         ),
        .w_last           (w_last          ),
        .w_valid          (w_valid         ),
        .m_data           (m_data          ),
        .m_first          (m_first         ),
        .m_last           (m_last          ),
        .m_valid          (m_valid         ),
        .m_ready          (m_ready         ),
        .overflow         (overflow        )
    );

endmodule

`default_nettype wire

// ==== bench/tb_dphy_byte_rx_tests.svh ====
`ifndef TB_DPHY_BYTE_RX_TESTS_SVH
`define TB_DPHY_BYTE_RX_TESTS_SVH

// ------------------------------------------------------------
//  drive helpers move inputs 2 ns after the rising edge
// ------------------------------------------------------------
task automatic next_slot();
    @(posedge mipi_dphy_rx_clk);
    #2;
endtask

task automatic idle_cycles(input int n);
    repeat (n) next_slot();
endtask

task automatic drive_lp(input dphy_rx_pkg::lp_t lp, input int hold);
    lp_d0 = lp;                                     // both lanes move together
    lp_d1 = lp;
    idle_cycles(hold);
endtask

task automatic wait_termination();
    int n;
    n = 0;
    @(negedge mipi_dphy_rx_clk);
    while (odt_en != 2'b11 && n < WAIT_LIMIT) begin
        @(negedge mipi_dphy_rx_clk);
        n++;
    end
    if (odt_en != 2'b11) begin
        timeout_count++;
        $display("Timeout at %0t: termination never switched on", $time);
    end
endtask

// stop -> request -> bridge and then room for the settle window to open
task automatic enter_hs();
    drive_lp(dphy_rx_pkg::LP_01, 5);
    lp_d0 = dphy_rx_pkg::LP_00;
    lp_d1 = dphy_rx_pkg::LP_00;
    wait_termination();
    idle_cycles(2);                                 // window opens two rises after odt
endtask

task automatic leave_hs();
    drive_lp(dphy_rx_pkg::LP_11, SETTLE_CYCLES + 6); // window fully closed after this
endtask

task automatic send_burst(input int n);
    dphy_rx_pkg::byte_t b0;
    dphy_rx_pkg::byte_t b1;
    sent.delete();
    hs_vld = 1'b1;
    hs_d0  = dphy_rx_pkg::SYNC_BYTE;                // leading sync pair yields no word
    hs_d1  = dphy_rx_pkg::SYNC_BYTE;
    next_slot();
    for (int i = 0; i < n; i++) begin
        b0    = dphy_rx_pkg::byte_t'($urandom);
        b1    = dphy_rx_pkg::byte_t'($urandom);
        hs_d0 = b0;
        hs_d1 = b1;
        sent.push_back({b1, b0});                   // lane 1 lands in the high byte
        next_slot();
    end
    hs_vld = 1'b0;
endtask

task automatic wait_words(input int total, input string what);
    int n;
    n = 0;
    while (rx_data.size() < total && n < WAIT_LIMIT) begin
        next_slot();                                // queue grows on falling edges
        n++;
    end
    if (rx_data.size() < total) begin
        timeout_count++;
        $display("Timeout at %0t: %s received %0d of %0d words", $time, what,
                 rx_data.size(), total);
    end
endtask

task automatic wait_overflow();
    int n;
    n = 0;
    @(negedge mipi_dphy_rx_clk);
    while (!overflow && n < WAIT_LIMIT) begin
        @(negedge mipi_dphy_rx_clk);
        n++;
    end
    if (!overflow) begin
        timeout_count++;
        $display("Timeout at %0t: overflow never raised with a full buffer", $time);
    end
endtask

// first flag on word 0 and last flag on the final word if the burst end survived
task automatic check_burst(input int base, input int n, input logic has_last);
    for (int i = 0; i < n; i++)
        check_word(rx_data[base + i], sent[i], rx_first[base + i], i == 0,
                   rx_last[base + i], has_last && (i == n - 1), $sformatf("word %0d", i));
endtask

// ------------------------------------------------------------
//  directed tests
// ------------------------------------------------------------
task automatic termination_sequence();
    drive_lp(2'b10, 5);                             // out of order without a request
    lp_d0 = dphy_rx_pkg::LP_00;
    lp_d1 = dphy_rx_pkg::LP_00;
    for (int i = 0; i < 8; i++) begin
        @(negedge mipi_dphy_rx_clk);
        check_bit(|odt_en, 1'b0, "odt_en after 11-10-00");
    end
    next_slot();
    drive_lp(dphy_rx_pkg::LP_11, 5);
    enter_hs();
    check_bit(odt_en[0], 1'b1, "odt_en lane 0 in bridge");
    check_bit(odt_en[1], 1'b1, "odt_en lane 1 in bridge");
    lp_d0 = dphy_rx_pkg::LP_11;
    lp_d1 = dphy_rx_pkg::LP_11;
    @(negedge mipi_dphy_rx_clk);                    // odt follows the raw lines
    check_bit(|odt_en, 1'b0, "odt_en after return to 11");
    next_slot();
    leave_hs();
endtask

task automatic aligner_reset_count();
    int start;
    start = ar_cycles;
    drive_lp(dphy_rx_pkg::LP_01, 5);                // request dropped back to stop
    drive_lp(dphy_rx_pkg::LP_11, 5);
    drive_lp(2'b10, 5);
    drive_lp(dphy_rx_pkg::LP_00, 5);
    drive_lp(dphy_rx_pkg::LP_11, 5);
    check_bit(ar_cycles == start, 1'b1, "aligner_reset outside entry sequence");
    enter_hs();
    idle_cycles(4);
    leave_hs();
    check_bit(ar_cycles == start + 1, 1'b1, "aligner_reset one cycle per entry");
endtask

task automatic burst_framing();
    int base;
    base = rx_data.size();
    enter_hs();
    send_burst(8);
    leave_hs();
    wait_words(base + 8, "burst");
    check_burst(base, 8, 1'b1);
    check_bit(rx_data.size() == base + 8, 1'b1, "burst word count");
endtask

task automatic settle_window_close();
    int base;
    enter_hs();
    drive_lp(dphy_rx_pkg::LP_11, SETTLE_CYCLES + 4); // past the hs tail
    base = rx_data.size();
    send_burst(6);
    idle_cycles(10);
    check_bit(rx_data.size() == base, 1'b1, "words after settle window closed");
    leave_hs();
endtask

task automatic backpressure_drain();
    int base;
    base    = rx_data.size();
    m_ready = 1'b0;
    enter_hs();
    send_burst(FIFO_DEPTH);                         // exactly fills the buffer
    leave_hs();
    check_bit(overflow, 1'b0, "overflow with a full but not overrun buffer");
    m_ready = 1'b1;
    wait_words(base + FIFO_DEPTH, "back-pressure");
    idle_cycles(4);
    check_burst(base, FIFO_DEPTH, 1'b1);
    check_bit(rx_data.size() == base + FIFO_DEPTH, 1'b1, "back-pressure word count");
    check_bit(overflow, 1'b0, "overflow after back-pressure drain");
endtask

task automatic overflow_drop();
    int base;
    base    = rx_data.size();
    m_ready = 1'b0;
    enter_hs();
    send_burst(FIFO_DEPTH + 4);                     // tail of the burst is lost
    wait_overflow();
    next_slot();
    leave_hs();
    m_ready = 1'b1;
    wait_words(base + FIFO_DEPTH, "overflow drain");
    idle_cycles(6);
    check_burst(base, FIFO_DEPTH, 1'b0);
    check_bit(rx_data.size() == base + FIFO_DEPTH, 1'b1, "overflow drain word count");
    check_bit(overflow, 1'b1, "overflow held after drain");
endtask

`endif

// ==== bench/tb_dphy_byte_rx.sv ====
`timescale 1ns/1ps

module tb_dphy_byte_rx;

    localparam int SETTLE_CYCLES = 10;              // same as dut default
    localparam int FIFO_DEPTH    = 16;
    localparam int WAIT_LIMIT    = 200;             // cycles per wait loop

    // ------------------------------------------------------------
    //  dut signals
    // ------------------------------------------------------------
    logic                          mipi_dphy_rx_clk = 1'b0;
    logic                          in_reset;
    dphy_rx_pkg::lp_t              lp_d0;
    dphy_rx_pkg::lp_t              lp_d1;
    dphy_rx_pkg::byte_t            hs_d0;
    dphy_rx_pkg::byte_t            hs_d1;
    logic                          hs_vld;
    logic [dphy_rx_pkg::LANES-1:0] odt_en;
    logic                          aligner_reset;
    dphy_rx_pkg::word_t            m_data;
    logic                          m_valid;
    logic                          m_first;
    logic                          m_last;
    logic                          m_ready;
    logic                          overflow;

    dphy_rx_pkg::word_t rx_data[$];                 // every word taken from m_
    logic               rx_first[$];
    logic               rx_last[$];
    dphy_rx_pkg::word_t sent[$];                    // payload of the last burst
    int                 ar_cycles       = 0;        // cycles with aligner_reset high
    int                 mismatch_count  = 0;
    int                 timeout_count   = 0;

    always #10 mipi_dphy_rx_clk = ~mipi_dphy_rx_clk;

    dphy_byte_rx_top #(
        .SETTLE_CYCLES (SETTLE_CYCLES),
        .FIFO_DEPTH    (FIFO_DEPTH   )
    ) dphy_byte_rx_top_i (.*);

    // handshake seen mid cycle completes on the next rise
    always @(negedge mipi_dphy_rx_clk) begin
        if (!in_reset && m_valid && m_ready) begin
            rx_data.push_back(m_data);
            rx_first.push_back(m_first);
            rx_last.push_back(m_last);
        end
        if (!in_reset && aligner_reset)
            ar_cycles++;
    end

    // ------------------------------------------------------------
    //  compare tasks
    // ------------------------------------------------------------
    task automatic check_word(input dphy_rx_pkg::word_t got, input dphy_rx_pkg::word_t exp,
                              input logic got_first, input logic exp_first,
                              input logic got_last, input logic exp_last, input string what);
        if (got !== exp || got_first !== exp_first || got_last !== exp_last) begin
            mismatch_count++;
            $display("Mismatch at %0t: %s got %h first %b last %b, expected %h first %b last %b",
                     $time, what, got, got_first, got_last, exp, exp_first, exp_last);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            mismatch_count++;
            $display("Mismatch at %0t: %s got %b, expected %b", $time, what, got, exp);
        end
    endtask

    `include "tb_dphy_byte_rx_tests.svh"

    initial begin
        void'($urandom(32'h8fce_f0fb));             // burst payloads repeat run to run
        in_reset = 1'b1;
        lp_d0    = dphy_rx_pkg::LP_11;              // lines idle in stop
        lp_d1    = dphy_rx_pkg::LP_11;
        hs_d0    = '0;
        hs_d1    = '0;
        hs_vld   = 1'b0;
        m_ready  = 1'b1;
        repeat (3) @(posedge mipi_dphy_rx_clk);
        #2 in_reset = 1'b0;
        @(negedge mipi_dphy_rx_clk);
        check_bit(|odt_en, 1'b0, "odt_en after reset");
        check_bit(aligner_reset, 1'b0, "aligner_reset after reset");
        check_bit(m_valid, 1'b0, "m_valid after reset");
        check_bit(overflow, 1'b0, "overflow after reset");
        next_slot();
        termination_sequence();
        aligner_reset_count();
        burst_framing();
        settle_window_close();
        backpressure_drain();
        overflow_drop();                            // runs last since overflow stays set
        $display("errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+bench
hw/dphy_rx_pkg.sv
hw/lp_state_monitor.sv
hw/hs_settle_timer.sv
hw/hs_byte_capture.sv
hw/burst_fifo.sv
hw/dphy_byte_rx_top.sv
bench/tb_dphy_byte_rx.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_dphy_byte_rx
RTL_TOP   ?= dphy_byte_rx_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(wildcard hw/*.sv) $(wildcard bench/*.sv) $(wildcard bench/*.svh)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "STATUS: PASS" $(LOG) || (echo "simulation ended without a result"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing -Wall -f $(FILELIST) --top-module $(TOP)
	$(VERILATOR) --lint-only -Wall hw/*.sv --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
